// ==== cart_top.f ====
hw/cart_pkg.sv
hw/n64_pi_port.sv
hw/host_port.sv
hw/mem_arbiter.sv
hw/cart_sram.sv
hw/cart_gpio.sv
hw/cart_top.sv
verif/cart_properties.sv
verif/cart_tb.sv

// ==== hw/cart_gpio.sv ====
module cart_gpio (
    input  logic                i_sys,
    input  logic                i_rst_n,
    input  logic                i_we,
    input  cart_pkg::mem_data_t i_wdata,
    input  logic                i_addr_sel,
    output cart_pkg::mem_data_t o_rdata,
    input  logic                i_n64_nmi,
    input  logic                i_n64_reset,
    output logic                o_led,
    output logic                o_n64_irq
);

    import cart_pkg::*;

    gpio_t gpio_out;
    gpio_t gpio_oe;
    gpio_t gpio_in;

    // low byte drives the pins, high byte enables them
    always_ff @(posedge i_sys or negedge i_rst_n) begin
        if (!i_rst_n) begin
            gpio_out <= '0;
            gpio_oe  <= '0;
        end else if (i_we) begin
            gpio_out <= i_wdata[GPIO_W-1:0];
            gpio_oe  <= i_wdata[DATA_W-1:GPIO_W];
        end
    end

    always_ff @(posedge i_sys) begin
        gpio_in <= {4'b0000, i_n64_nmi, i_n64_reset, gpio_out[1:0]};
    end

    assign o_led     = gpio_oe[0] ? gpio_out[0] : 1'bz;
    assign o_n64_irq = gpio_oe[1] ? gpio_out[1] : 1'bz;

    // sel high picks the input word
    assign o_rdata = i_addr_sel ? {{GPIO_W{1'b0}}, gpio_in} : {gpio_oe, gpio_out};

endmodule

// ==== hw/cart_pkg.sv ====
package cart_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int MEM_WORDS = 1024;
    localparam int DATA_W    = 16;
    localparam int ADDR_W    = $clog2(MEM_WORDS);
    localparam int PI_AW     = 32;
    localparam int HOST_AW   = 12;
    localparam int GPIO_W    = 8;

    // host address bit that steers an access to the gpio block
    localparam int HOST_GPIO_BIT = 11;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [DATA_W-1:0]  mem_data_t;
    typedef logic [ADDR_W-1:0]  mem_addr_t;
    typedef logic [PI_AW-1:0]   pi_addr_t;
    typedef logic [HOST_AW-1:0] host_addr_t;
    typedef logic [GPIO_W-1:0]  gpio_t;

    // one memory access, qualified by a separate valid pulse
    typedef struct packed {
        logic      we;
        mem_addr_t addr;
        mem_data_t data;
    } mem_req_t;

    typedef enum logic [1:0] {
        idle,
        read_wait,
        read_drive
    } pi_state_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address map
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // upper pi address half decoded as cartridge space
    localparam logic [15:0] CART_BASE_HI = 16'h1000;

    // word indexes inside the gpio region
    localparam mem_addr_t GPIO_REG_OUT = mem_addr_t'(0);
    localparam mem_addr_t GPIO_REG_IN  = mem_addr_t'(1);

endpackage

// ==== hw/cart_sram.sv ====
module cart_sram (
    input  logic                i_sys,
    input  logic                i_mem_en,
    input  cart_pkg::mem_req_t  i_mem_req,
    output cart_pkg::mem_data_t o_rdata
);

    import cart_pkg::*;

    mem_data_t mem [MEM_WORDS];

    // one port, read data registered
    always_ff @(posedge i_sys) begin
        if (i_mem_en) begin
            if (i_mem_req.we) begin
                mem[i_mem_req.addr] <= i_mem_req.data;
            end else begin
                o_rdata <= mem[i_mem_req.addr];
            end
        end
    end

endmodule

// ==== hw/cart_top.sv ====
module cart_top (
    input  logic                 i_sys,
    input  logic                 i_rst_n,

    input  logic                 i_pi_alel,
    input  logic                 i_pi_aleh,
    input  logic                 i_pi_read,
    input  logic                 i_pi_write,
    input  cart_pkg::mem_data_t  i_pi_ad,
    output cart_pkg::mem_data_t  o_pi_ad,
    output logic                 o_pi_ad_oe,

    input  logic                 i_host_req,
    input  logic                 i_host_we,
    input  cart_pkg::host_addr_t i_host_addr,
    input  cart_pkg::mem_data_t  i_host_wdata,
    output logic                 o_host_ack,
    output cart_pkg::mem_data_t  o_host_rdata,

    input  logic                 i_n64_nmi,
    input  logic                 i_n64_reset,
    output logic                 o_led,
    output logic                 o_n64_irq
);

    import cart_pkg::*;

    mem_req_t  pi_req;
    logic      pi_req_valid;
    mem_req_t  host_req;
    logic      host_req_valid;
    logic      pi_rvalid;
    logic      host_rvalid;
    logic      host_wdone;
    mem_data_t rdata;
    mem_data_t mem_rdata;
    mem_req_t  mem_req;
    logic      mem_en;
    logic      gpio_we;
    logic      gpio_sel;
    mem_data_t gpio_wdata;
    mem_data_t gpio_rdata;

    n64_pi_port u_pi (
        .i_sys       (i_sys),
        .i_rst_n     (i_rst_n),
        .i_pi_alel   (i_pi_alel),
        .i_pi_aleh   (i_pi_aleh),
        .i_pi_read   (i_pi_read),
        .i_pi_write  (i_pi_write),
        .i_pi_ad     (i_pi_ad),
        .o_pi_ad     (o_pi_ad),
        .o_pi_ad_oe  (o_pi_ad_oe),
        .o_req       (pi_req),
        .o_req_valid (pi_req_valid),
        .i_rvalid    (pi_rvalid),
        .i_rdata     (rdata)
    );

    host_port u_host (
        .i_sys        (i_sys),
        .i_rst_n      (i_rst_n),
        .i_host_req   (i_host_req),
        .i_host_we    (i_host_we),
        .i_host_addr  (i_host_addr),
        .i_host_wdata (i_host_wdata),
        .o_host_ack   (o_host_ack),
        .o_host_rdata (o_host_rdata),
        .o_req        (host_req),
        .o_req_valid  (host_req_valid),
        .i_rvalid     (host_rvalid),
        .i_rdata      (rdata),
        .i_wdone      (host_wdone),
        .o_gpio_we    (gpio_we),
        .o_gpio_sel   (gpio_sel),
        .o_gpio_wdata (gpio_wdata),
        .i_gpio_rdata (gpio_rdata)
    );

    mem_arbiter u_arb (
        .i_sys            (i_sys),
        .i_rst_n          (i_rst_n),
        .i_pi_req         (pi_req),
        .i_pi_req_valid   (pi_req_valid),
        .i_host_req       (host_req),
        .i_host_req_valid (host_req_valid),
        .o_pi_rvalid      (pi_rvalid),
        .o_host_rvalid    (host_rvalid),
        .o_host_wdone     (host_wdone),
        .o_rdata          (rdata),
        .i_mem_rdata      (mem_rdata),
        .o_mem_req        (mem_req),
        .o_mem_en         (mem_en)
    );

    cart_sram u_sram (
        .i_sys     (i_sys),
        .i_mem_en  (mem_en),
        .i_mem_req (mem_req),
        .o_rdata   (mem_rdata)
    );

    cart_gpio u_gpio (
        .i_sys       (i_sys),
        .i_rst_n     (i_rst_n),
        .i_we        (gpio_we),
        .i_wdata     (gpio_wdata),
        .i_addr_sel  (gpio_sel),
        .o_rdata     (gpio_rdata),
        .i_n64_nmi   (i_n64_nmi),
        .i_n64_reset (i_n64_reset),
        .o_led       (o_led),
        .o_n64_irq   (o_n64_irq)
    );

endmodule

// ==== hw/host_port.sv ====
module host_port (
    input  logic                 i_sys,
    input  logic                 i_rst_n,
    input  logic                 i_host_req,
    input  logic                 i_host_we,
    input  cart_pkg::host_addr_t i_host_addr,
    input  cart_pkg::mem_data_t  i_host_wdata,
    output logic                 o_host_ack,
    output cart_pkg::mem_data_t  o_host_rdata,
    output cart_pkg::mem_req_t   o_req,
    output logic                 o_req_valid,
    input  logic                 i_rvalid,
    input  cart_pkg::mem_data_t  i_rdata,
    input  logic                 i_wdone,
    output logic                 o_gpio_we,
    output logic                 o_gpio_sel,
    output cart_pkg::mem_data_t  o_gpio_wdata,
    input  cart_pkg::mem_data_t  i_gpio_rdata
);

    import cart_pkg::*;

    logic      gpio_hit;
    mem_addr_t word;
    logic      mem_busy;

    assign gpio_hit = i_host_addr[HOST_GPIO_BIT];
    assign word     = i_host_addr[ADDR_W-1:0];

    // memory side
    assign o_req_valid = i_host_req & ~gpio_hit;
    assign o_req.we    = i_host_we;
    assign o_req.addr  = word;
    assign o_req.data  = i_host_wdata;

    // gpio side, only the output register is writable
    assign o_gpio_we    = i_host_req & gpio_hit & i_host_we & (word == GPIO_REG_OUT);
    assign o_gpio_sel   = (word == GPIO_REG_IN);
    assign o_gpio_wdata = i_host_wdata;

    // busy covers one memory access until the arbiter reports it done
    always_ff @(posedge i_sys or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mem_busy   <= 1'b0;
            o_host_ack <= 1'b0;
        end else begin
            o_host_ack <= 1'b0;
            if (o_req_valid) begin
                mem_busy <= 1'b1;
            end else if (mem_busy && (i_wdone || i_rvalid)) begin
                mem_busy   <= 1'b0;
                o_host_ack <= 1'b1;
            end
            // gpio answers on the next cycle
            if (i_host_req && gpio_hit) begin
                o_host_ack <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_sys) begin
        if (i_host_req && gpio_hit) begin
            o_host_rdata <= i_gpio_rdata;
        end else if (i_rvalid) begin
            o_host_rdata <= i_rdata;
        end
    end

endmodule

// ==== hw/mem_arbiter.sv ====
module mem_arbiter (
    input  logic                i_sys,
    input  logic                i_rst_n,
    input  cart_pkg::mem_req_t  i_pi_req,
    input  logic                i_pi_req_valid,
    input  cart_pkg::mem_req_t  i_host_req,
    input  logic                i_host_req_valid,
    output logic                o_pi_rvalid,
    output logic                o_host_rvalid,
    output logic                o_host_wdone,
    output cart_pkg::mem_data_t o_rdata,
    input  cart_pkg::mem_data_t i_mem_rdata,
    output cart_pkg::mem_req_t  o_mem_req,
    output logic                o_mem_en
);

    import cart_pkg::*;

    mem_req_t pi_slot;
    logic     pi_pend;
    mem_req_t host_slot;
    logic     host_pend;

    logic     gnt_pi;
    logic     gnt_host;

    logic     rd_busy;
    logic     rd_owner_pi;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pending slots
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge i_sys or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pi_pend   <= 1'b0;
            host_pend <= 1'b0;
        end else begin
            if (i_pi_req_valid) begin
                pi_pend <= 1'b1;
            end else if (gnt_pi) begin
                pi_pend <= 1'b0;
            end
            if (i_host_req_valid) begin
                host_pend <= 1'b1;
            end else if (gnt_host) begin
                host_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_sys) begin
        if (i_pi_req_valid) begin
            pi_slot <= i_pi_req;
        end
        if (i_host_req_valid) begin
            host_slot <= i_host_req;
        end
    end

    // fixed priority, console first
    assign gnt_pi    = pi_pend;
    assign gnt_host  = host_pend & ~pi_pend;
    assign o_mem_en  = gnt_pi | gnt_host;
    assign o_mem_req = gnt_pi ? pi_slot : host_slot;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read return
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge i_sys or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rd_busy      <= 1'b0;
            rd_owner_pi  <= 1'b0;
            o_host_wdone <= 1'b0;
        end else begin
            rd_busy      <= o_mem_en & ~o_mem_req.we;
            rd_owner_pi  <= gnt_pi;
            o_host_wdone <= gnt_host & host_slot.we;
        end
    end

    // memory data arrives in the same cycle as the return pulse
    assign o_pi_rvalid   = rd_busy & rd_owner_pi;
    assign o_host_rvalid = rd_busy & ~rd_owner_pi;
    assign o_rdata       = i_mem_rdata;

endmodule

// ==== hw/n64_pi_port.sv ====
module n64_pi_port (
    input  logic                i_sys,
    input  logic                i_rst_n,
    input  logic                i_pi_alel,
    input  logic                i_pi_aleh,
    input  logic                i_pi_read,
    input  logic                i_pi_write,
    input  cart_pkg::mem_data_t i_pi_ad,
    output cart_pkg::mem_data_t o_pi_ad,
    output logic                o_pi_ad_oe,
    output cart_pkg::mem_req_t  o_req,
    output logic                o_req_valid,
    input  logic                i_rvalid,
    input  cart_pkg::mem_data_t i_rdata
);

    import cart_pkg::*;

    // strobe vector order is aleh, alel, read, write
    logic [3:0] strb_meta;
    logic [3:0] strb_sync;
    logic [1:0] strb_prev;
    mem_data_t  ad_meta;
    mem_data_t  ad_sync;

    logic       aleh_s;
    logic       alel_s;
    logic       read_fall;
    logic       read_rise;
    logic       write_rise;

    pi_addr_t   addr;
    logic       hit;
    pi_state_t  state;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // synchronizers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // idle bus has ale low and read/write high
    always_ff @(posedge i_sys or negedge i_rst_n) begin
        if (!i_rst_n) begin
            strb_meta <= 4'b0011;
            strb_sync <= 4'b0011;
            strb_prev <= 2'b11;
        end else begin
            strb_meta <= {i_pi_aleh, i_pi_alel, i_pi_read, i_pi_write};
            strb_sync <= strb_meta;
            strb_prev <= strb_sync[1:0];
        end
    end

    // AD follows the same delay so it lines up with the strobes
    always_ff @(posedge i_sys) begin
        ad_meta <= i_pi_ad;
        ad_sync <= ad_meta;
    end

    assign aleh_s     = strb_sync[3];
    assign alel_s     = strb_sync[2];
    assign read_fall  = strb_prev[1] & ~strb_sync[1];
    assign read_rise  = ~strb_prev[1] & strb_sync[1];
    assign write_rise = ~strb_prev[0] & strb_sync[0];

    assign hit = (addr[31:16] == CART_BASE_HI);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address and bus cycle FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge i_sys or negedge i_rst_n) begin
        if (!i_rst_n) begin
            addr        <= '0;
            state       <= idle;
            o_req_valid <= 1'b0;
        end else begin
            o_req_valid <= 1'b0;

            if (aleh_s) begin
                addr[31:16] <= ad_sync;
            end else if (alel_s) begin
                addr[15:0] <= ad_sync;
            end else if (read_rise || write_rise) begin
                addr <= addr + pi_addr_t'(2);
            end

            case (state)
                idle: begin
                    if (read_fall && hit) begin
                        o_req_valid <= 1'b1;
                        state       <= read_wait;
                    end else if (write_rise && hit) begin
                        o_req_valid <= 1'b1;
                    end
                end
                read_wait: begin
                    if (read_rise) begin
                        state <= idle;
                    end else if (i_rvalid) begin
                        state <= read_drive;
                    end
                end
                read_drive: begin
                    if (read_rise) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // request payload, write data taken at the write strobe edge
    always_ff @(posedge i_sys) begin
        if (read_fall || write_rise) begin
            o_req.we   <= write_rise;
            o_req.addr <= addr[10:1];
            o_req.data <= ad_sync;
        end
        if (state == read_wait && i_rvalid) begin
            o_pi_ad <= i_rdata;
        end
    end

    // release the bus as soon as the console lifts READ
    assign o_pi_ad_oe = (state == read_drive) & ~i_pi_read;

endmodule

// ==== verif/cart_properties.sv ====
module cart_properties (
    input logic i_sys,
    input logic i_rst_n,
    input logic i_pi_read,
    input logic i_pi_ad_oe,
    input logic i_host_req,
    input logic i_host_ack,
    input logic i_pi_req_valid,
    input logic i_host_req_valid,
    input logic i_mem_en
);

    logic        host_open;
    logic [1:0]  owed;
    int unsigned fail_cnt;

    initial begin
        fail_cnt = 0;
    end

    // a host access is open from its request until its acknowledge
    always_ff @(posedge i_sys or negedge i_rst_n) begin
        if (!i_rst_n) begin
            host_open <= 1'b0;
        end else if (i_host_req) begin
            host_open <= 1'b1;
        end else if (i_host_ack) begin
            host_open <= 1'b0;
        end
    end

    // memory requests accepted by the arbiter and not yet issued
    always_ff @(posedge i_sys or negedge i_rst_n) begin
        if (!i_rst_n) begin
            owed <= 2'd0;
        end else begin
            owed <= owed + 2'(i_pi_req_valid) + 2'(i_host_req_valid) - 2'(i_mem_en);
        end
    end

    a_oe_in_read: assert property (@(posedge i_sys) disable iff (!i_rst_n)
        i_pi_ad_oe |-> !i_pi_read)
    else begin
        fail_cnt++;
        $error("AD driven while READ is high");
    end

    a_ack_after_req: assert property (@(posedge i_sys) disable iff (!i_rst_n)
        i_host_ack |-> host_open)
    else begin
        fail_cnt++;
        $error("host acknowledge without a request");
    end

    // a merged grant would leave a request owed while memory sits idle
    a_one_issue: assert property (@(posedge i_sys) disable iff (!i_rst_n)
        i_mem_en == (owed != 2'd0))
    else begin
        fail_cnt++;
        $error("arbiter issues did not match the accepted requests");
    end

endmodule

bind cart_top cart_properties u_props (
    .i_sys            (i_sys),
    .i_rst_n          (i_rst_n),
    .i_pi_read        (i_pi_read),
    .i_pi_ad_oe       (o_pi_ad_oe),
    .i_host_req       (i_host_req),
    .i_host_ack       (o_host_ack),
    .i_pi_req_valid   (pi_req_valid),
    .i_host_req_valid (host_req_valid),
    .i_mem_en         (mem_en)
);

// ==== verif/cart_tb.sv ====
module cart_tb;

    import cart_pkg::*;

    typedef struct packed {
        logic      chk;
        logic      as_gpio;
        mem_data_t val;
    } host_exp_t;

    typedef struct packed {
        gpio_t in_word;
        logic  irq;
        logic  led;
    } gpio_exp_t;

    localparam int CLK_PERIOD    = 4;
    localparam int BURST         = 16;
    localparam int SMALL         = 8;
    localparam int GPIO_ROUNDS   = 8;
    localparam int HOST_RAND     = 24;
    localparam int HOST_WAIT_MAX = 20;
    // pi read 16, pi write 9, address phase 11, host access 12 cycles at most
    localparam int RUN_CYCLES = (2 * BURST + SMALL) * (16 + 9) + 6 * 11
                              + (3 * BURST + 2 * SMALL + 3 * GPIO_ROUNDS + HOST_RAND) * 12
                              + 500;

    localparam host_addr_t GPIO_BASE = host_addr_t'(1 << HOST_GPIO_BIT);
    localparam mem_addr_t  BLK_HOST  = mem_addr_t'(10'h040);
    localparam mem_addr_t  BLK_WRAP  = mem_addr_t'(MEM_WORDS - 6);
    localparam mem_addr_t  BLK_MISS  = mem_addr_t'(10'h200);
    localparam mem_addr_t  BLK_PI    = mem_addr_t'(10'h100);

    logic       sys;
    logic       rst_n;
    logic       pi_alel;
    logic       pi_aleh;
    logic       pi_read;
    logic       pi_write;
    mem_data_t  pi_ad;
    mem_data_t  pi_ad_out;
    logic       pi_ad_oe;
    logic       host_req;
    logic       host_we;
    host_addr_t host_addr;
    mem_data_t  host_wdata;
    logic       host_ack;
    mem_data_t  host_rdata;
    logic       n64_nmi;
    logic       n64_reset;
    logic       led;
    logic       n64_irq;

    mem_data_t  model [MEM_WORDS];
    host_exp_t  host_q [$];
    mem_data_t  pi_q [$];
    logic       pi_sample;
    logic       pi_quiet;
    mem_data_t  gpio_reg;

    cart_top u_dut (
        .i_sys        (sys),
        .i_rst_n      (rst_n),
        .i_pi_alel    (pi_alel),
        .i_pi_aleh    (pi_aleh),
        .i_pi_read    (pi_read),
        .i_pi_write   (pi_write),
        .i_pi_ad      (pi_ad),
        .o_pi_ad      (pi_ad_out),
        .o_pi_ad_oe   (pi_ad_oe),
        .i_host_req   (host_req),
        .i_host_we    (host_we),
        .i_host_addr  (host_addr),
        .i_host_wdata (host_wdata),
        .o_host_ack   (host_ack),
        .o_host_rdata (host_rdata),
        .i_n64_nmi    (n64_nmi),
        .i_n64_reset  (n64_reset),
        .o_led        (led),
        .o_n64_irq    (n64_irq)
    );

    initial begin
        sys = 1'b0;
        forever #(CLK_PERIOD / 2) sys = ~sys;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference and compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_data(input mem_data_t got, input mem_data_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH @ %0t: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_gpio(input gpio_t got, input gpio_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH @ %0t: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_pins(input logic [1:0] got, input logic [1:0] exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH @ %0t: %s got %b expected %b", $time, what, got, exp));
        end
    endtask

    // pins float unless enabled, input word is {0000, nmi, reset, out[1:0]}
    function automatic gpio_exp_t gpio_expect(input mem_data_t reg_val, input logic nmi,
                                              input logic rst);
        gpio_exp_t e;
        e.in_word = {4'b0000, nmi, rst, reg_val[1:0]};
        e.led     = reg_val[8] ? reg_val[0] : 1'bz;
        e.irq     = reg_val[9] ? reg_val[1] : 1'bz;
        return e;
    endfunction

    always @(posedge sys) begin : compare_results
        host_exp_t h;
        mem_data_t p;
        if (host_ack === 1'b1) begin
            if (host_q.size() == 0) begin
                abort_run("host acknowledge with no access outstanding");
            end
            h = host_q.pop_front();
            if (h.chk && h.as_gpio) begin
                check_gpio(host_rdata[7:0], h.val[7:0], "gpio input word");
                check_gpio(host_rdata[15:8], '0, "gpio input upper byte");
            end else if (h.chk) begin
                check_data(host_rdata, h.val, "host read");
            end
        end
        if (pi_sample) begin
            if (pi_ad_oe !== 1'b1) begin
                abort_run("PI read data was not driven within the READ window");
            end
            p = pi_q.pop_front();
            check_data(pi_ad_out, p, "PI read");
        end
        if (pi_quiet && pi_ad_oe !== 1'b0) begin
            abort_run("PI port drove AD for an address outside the cartridge");
        end
        if (u_dut.u_props.fail_cnt != 0) begin
            abort_run("a bound assertion failed");
        end
    end

    initial begin : watchdog
        #(RUN_CYCLES * CLK_PERIOD);
        abort_run($sformatf("timeout: run did not finish within %0d cycles", RUN_CYCLES));
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus drivers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic host_access(input logic we, input host_addr_t a, input mem_data_t wd,
                               input host_exp_t exp);
        int waited;
        @(posedge sys);
        host_req   <= 1'b1;
        host_we    <= we;
        host_addr  <= a;
        host_wdata <= wd;
        host_q.push_back(exp);
        @(posedge sys);
        host_req <= 1'b0;
        waited = 0;
        @(posedge sys);
        while (host_ack !== 1'b1) begin
            if (waited == HOST_WAIT_MAX) begin
                abort_run("host access was never acknowledged");
            end
            waited++;
            @(posedge sys);
        end
        if (a[HOST_GPIO_BIT] && waited != 0) begin
            abort_run("GPIO access acknowledged later than one cycle after the request");
        end
    endtask

    task automatic host_write_mem(input mem_addr_t w, input mem_data_t d);
        model[w] = d;
        host_access(1'b1, host_addr_t'(w), d, '{chk: 1'b0, as_gpio: 1'b0, val: '0});
    endtask

    task automatic host_read_mem(input mem_addr_t w);
        host_access(1'b0, host_addr_t'(w), '0, '{chk: 1'b1, as_gpio: 1'b0, val: model[w]});
    endtask

    // upper half with both ALE high, then lower half with ALEL only
    task automatic pi_address(input pi_addr_t a);
        @(posedge sys);
        pi_aleh <= 1'b1;
        pi_alel <= 1'b1;
        pi_ad   <= a[31:16];
        repeat (3) @(posedge sys);
        pi_aleh <= 1'b0;
        pi_ad   <= a[15:0];
        repeat (3) @(posedge sys);
        pi_alel <= 1'b0;
        repeat (4) @(posedge sys);
    endtask

    task automatic pi_read_cycle(input logic hit, input mem_data_t exp);
        @(posedge sys);
        pi_read <= 1'b0;
        if (hit) begin
            pi_q.push_back(exp);
        end
        repeat (11) @(posedge sys);
        pi_sample <= hit;
        @(posedge sys);
        pi_read   <= 1'b1;
        pi_sample <= 1'b0;
        repeat (3) @(posedge sys);
    endtask

    task automatic pi_write_cycle(input mem_data_t d);
        @(posedge sys);
        pi_write <= 1'b0;
        pi_ad    <= d;
        repeat (3) @(posedge sys);
        pi_write <= 1'b1;
        repeat (4) @(posedge sys);
    endtask

    task automatic pi_burst_write(input logic [15:0] hi, input mem_addr_t w, input int n);
        mem_data_t d;
        int        i;
        pi_address({hi, 5'b00000, w, 1'b0});
        for (i = 0; i < n; i++) begin
            d = mem_data_t'($urandom);
            pi_write_cycle(d);
            if (hi == CART_BASE_HI) begin
                model[mem_addr_t'(w + i)] = d;
            end
        end
    endtask

    task automatic pi_burst_read(input logic [15:0] hi, input mem_addr_t w, input int n);
        int i;
        pi_address({hi, 5'b00000, w, 1'b0});
        for (i = 0; i < n; i++) begin
            pi_read_cycle(hi == CART_BASE_HI, model[mem_addr_t'(w + i)]);
        end
    endtask

    task automatic gpio_round();
        gpio_exp_t e;
        logic      nmi_lvl;
        logic      rst_lvl;
        gpio_reg = mem_data_t'($urandom);
        host_access(1'b1, GPIO_BASE | host_addr_t'(GPIO_REG_OUT), gpio_reg,
                    '{chk: 1'b0, as_gpio: 1'b0, val: '0});
        nmi_lvl = 1'($urandom_range(0, 1));
        rst_lvl = 1'($urandom_range(0, 1));
        @(posedge sys);
        n64_nmi   <= nmi_lvl;
        n64_reset <= rst_lvl;
        repeat (2) @(posedge sys);
        e = gpio_expect(gpio_reg, nmi_lvl, rst_lvl);
        check_pins({n64_irq, led}, {e.irq, e.led}, "irq/led pins");
        host_access(1'b0, GPIO_BASE | host_addr_t'(GPIO_REG_IN), '0,
                    '{chk: 1'b1, as_gpio: 1'b1, val: {8'h00, e.in_word}});
        host_access(1'b0, GPIO_BASE | host_addr_t'(GPIO_REG_OUT), '0,
                    '{chk: 1'b1, as_gpio: 1'b0, val: gpio_reg});
    endtask

    task automatic host_traffic(input int n);
        mem_addr_t w;
        int        i;
        for (i = 0; i < n; i++) begin
            w = mem_addr_t'(BLK_HOST + $urandom_range(0, BURST - 1));
            if ($urandom_range(0, 1) == 1) begin
                host_write_mem(w, mem_data_t'($urandom));
            end else begin
                host_read_mem(w);
            end
            repeat ($urandom_range(0, 3)) @(posedge sys);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin : main_sequence
        logic [15:0] other_hi;
        int          i;
        void'($urandom(32'h4b3a_8d68));
        rst_n      <= 1'b0;
        pi_alel    <= 1'b0;
        pi_aleh    <= 1'b0;
        pi_read    <= 1'b1;
        pi_write   <= 1'b1;
        pi_ad      <= '0;
        host_req   <= 1'b0;
        host_we    <= 1'b0;
        host_addr  <= '0;
        host_wdata <= '0;
        n64_nmi    <= 1'b0;
        n64_reset  <= 1'b0;
        pi_sample  <= 1'b0;
        pi_quiet   <= 1'b0;
        gpio_reg   = '0;
        repeat (3) @(posedge sys);
        rst_n <= 1'b1;
        repeat (2) @(posedge sys);

        // host fills a block, console bursts it back
        for (i = 0; i < BURST; i++) begin
            host_write_mem(mem_addr_t'(BLK_HOST + i), mem_data_t'($urandom));
        end
        pi_burst_read(CART_BASE_HI, BLK_HOST, BURST);

        // console burst across the top of memory, host reads back
        pi_burst_write(CART_BASE_HI, BLK_WRAP, BURST);
        for (i = 0; i < BURST; i++) begin
            host_read_mem(mem_addr_t'(BLK_WRAP + i));
        end

        // accesses outside the cartridge leave memory alone
        for (i = 0; i < SMALL; i++) begin
            host_write_mem(mem_addr_t'(BLK_MISS + i), mem_data_t'($urandom));
        end
        other_hi = 16'($urandom_range(0, 'h0fff));
        @(posedge sys);
        pi_quiet <= 1'b1;
        pi_burst_write(other_hi, BLK_MISS, SMALL);
        pi_burst_read(other_hi, BLK_MISS, SMALL);
        @(posedge sys);
        pi_quiet <= 1'b0;
        for (i = 0; i < SMALL; i++) begin
            host_read_mem(mem_addr_t'(BLK_MISS + i));
        end

        repeat (GPIO_ROUNDS) gpio_round();

        // host traffic while the console bursts
        fork
            begin
                pi_burst_write(CART_BASE_HI, BLK_PI, BURST);
                pi_burst_read(CART_BASE_HI, BLK_PI, BURST);
            end
            host_traffic(HOST_RAND);
        join

        repeat (4) @(posedge sys);
        if (host_q.size() == 0 && pi_q.size() == 0 && u_dut.u_props.fail_cnt == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            abort_run("expected results were left unchecked at the end of the run");
        end
    end

endmodule
